//--- Bender.yml
package:
  name: periph_soc

sources:
  - design/periph_pkg.sv
  - design/sync_fifo.sv
  - design/sd_ctrl_regs.sv
  - design/sd_status_mux.sv
  - design/periph_soc.sv
  - target: simulation
    files:
      - verif/periph_soc_checker.sv
      - verif/periph_soc_tb.sv

//--- design/periph_pkg.sv
// shared widths, region and sd register address enums, default read word
package periph_pkg;

  localparam int DATA_W   = 32;  // bus and fifo word
  localparam int ADDR_W   = 17;  // byte address width, port carries 16:2
  localparam int CNT_W    = 12;  // fifo read/write counts
  localparam int RESP_W   = 134; // crc in 6:0, four response words above
  localparam int PACKET_W = 48;

  localparam logic [DATA_W-1:0] DEAD_WORD = 32'hdeadbeef;

  typedef enum logic [1:0] {
    REGION_KEYB   = 2'd0,
    REGION_FB     = 2'd1,
    REGION_SD     = 2'd2,
    REGION_RXFIFO = 2'd3
  } periph_region_e;

  typedef enum logic [3:0] {
    SD_ALIGN     = 4'd0,
    SD_CMD_ARG   = 4'd2,
    SD_CMD_IDX   = 4'd3,
    SD_SETTING   = 4'd4,  // data start 5:3, cmd setting 2:0
    SD_CMD_START = 4'd5,
    SD_RESETS    = 4'd6,  // card reset, clk en, data en, cmd en
    SD_BLKCNT    = 4'd7,
    SD_BLKSIZE   = 4'd8,
    SD_TIMEOUT   = 4'd9,
    SD_LED       = 4'd15
  } sd_wr_addr_e;

  typedef enum logic [4:0] {
    SEL_RESP0 = 5'd0, SEL_RESP1 = 5'd1, SEL_RESP2 = 5'd2, SEL_RESP3 = 5'd3,
    SEL_CMD_WAIT   = 5'd4,
    SEL_STATUS     = 5'd5,
    SEL_PACKET_LO  = 5'd6,
    SEL_PACKET_HI  = 5'd7,
    SEL_DATA_WAIT  = 5'd8,
    SEL_TRANSF_CNT = 5'd9,
    SEL_RX_STATUS  = 5'd10,
    SEL_TX_STATUS  = 5'd11,
    SEL_DETECT     = 5'd12,
    SEL_ALIGN = 5'd16, SEL_CMD_ARG = 5'd18, SEL_CMD_IDX = 5'd19,
    SEL_SETTING = 5'd20, SEL_START = 5'd21, SEL_RESETS = 5'd22,
    SEL_BLKCNT = 5'd23, SEL_BLKSIZE = 5'd24, SEL_TIMEOUT = 5'd25,
    SEL_DIP = 5'd31
  } sd_rd_sel_e;

endpackage

//--- design/periph_soc.sv
// peripheral top: region decode, read-data merge, keyboard and sd fifos, sd registers
`timescale 1ns/1ns

module periph_soc
  import periph_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
)
(
  input  logic                msoc_clk,
  input  logic                rstn,
  input  logic                hid_req_i,
  input  logic                hid_we_i,
  input  logic [ADDR_W-3:0]   hid_addr_i,   // word address, byte bits 16:2
  input  logic [DATA_W-1:0]   hid_wrdata_i,
  output logic [DATA_W-1:0]   hid_rddata_o,
  input  logic                key_valid_i,
  input  logic [6:0]          key_ascii_i,
  input  logic [7:0]          key_scan_i,
  input  logic [15:0]         from_dip_i,
  input  logic                sd_detect_i,
  input  logic [27:0]         sd_status_i,
  input  logic [RESP_W-1:0]   sd_cmd_response_i,
  input  logic [DATA_W-1:0]   sd_cmd_wait_i,
  input  logic [DATA_W-1:0]   sd_data_wait_i,
  input  logic [PACKET_W-1:0] sd_cmd_packet_i,
  input  logic [15:0]         sd_transf_cnt_i,
  input  logic                sd_tx_rd_i,
  input  logic                sd_rx_we_i,
  input  logic [DATA_W-1:0]   sd_rx_data_i,
  output logic [DATA_W-1:0]   sd_tx_data_o,
  output logic [7:0]          to_led_o,
  output logic [1:0]          sd_align_o,
  output logic [31:0]         sd_cmd_arg_o,
  output logic [5:0]          sd_cmd_idx_o,
  output logic [2:0]          sd_cmd_setting_o,
  output logic [2:0]          sd_data_start_o,
  output logic                sd_cmd_start_o,
  output logic [15:0]         sd_blkcnt_o,
  output logic [11:0]         sd_blksize_o,
  output logic [31:0]         sd_timeout_o,
  output logic                sd_card_reset_o,
  output logic                sd_clk_en_o,
  output logic                sd_data_en_o,
  output logic                sd_cmd_en_o
);

  periph_region_e    region;
  logic              bus_wr;
  logic              keyb_pop;
  logic              sd_reg_wr;
  logic              tx_push;
  logic              rx_pop;
  logic              sd_fifo_clr;
  logic [DATA_W-1:0] region_rdata [4];
  logic [DATA_W-1:0] keyb_dout;
  logic [DATA_W-1:0] rx_dout;
  logic [DATA_W-1:0] sd_rdata;
  logic [DATA_W-1:0] tx_status;
  logic [DATA_W-1:0] rx_status;
  logic              tx_full, tx_empty, tx_almost_full, tx_wr_err, tx_rd_err;
  logic              rx_full, rx_empty, rx_almost_full, rx_wr_err, rx_rd_err;
  logic [CNT_W-1:0]  tx_wr_count, tx_rd_count;
  logic [CNT_W-1:0]  rx_wr_count, rx_rd_count;

  assign region      = periph_region_e'(hid_addr_i[ADDR_W-3:ADDR_W-4]);
  assign bus_wr      = hid_req_i && hid_we_i;
  assign keyb_pop    = bus_wr && (region == REGION_KEYB);  // a write pops the key queue
  assign sd_reg_wr   = bus_wr && (region == REGION_SD) && !hid_addr_i[12];
  assign tx_push     = bus_wr && (region == REGION_SD) && hid_addr_i[12];
  assign rx_pop      = bus_wr && (region == REGION_RXFIFO);
  assign sd_fifo_clr = !sd_data_en_o;

  assign tx_status = {4'b0, tx_almost_full, tx_full, tx_rd_err, tx_wr_err,
                      tx_rd_count, tx_wr_count};
  assign rx_status = {4'b0, rx_almost_full, rx_full, rx_rd_err, rx_wr_err,
                      rx_rd_count, rx_wr_count};

  assign region_rdata[REGION_KEYB]   = keyb_dout;
  assign region_rdata[REGION_FB]     = '0;  // no frame store
  assign region_rdata[REGION_SD]     = sd_rdata;
  assign region_rdata[REGION_RXFIFO] = rx_dout;

  always_comb
  begin
    hid_rddata_o = '0;
    for (int i = 0; i < 4; i++)
      if (region == periph_region_e'(i))
        hid_rddata_o |= region_rdata[i];
  end

  sync_fifo #(.WIDTH(DATA_W), .DEPTH(FIFO_DEPTH)) keyb_fifo (
    .msoc_clk(msoc_clk), .rstn(rstn), .clr_i(1'b0),
    .push_i(key_valid_i), .din_i(DATA_W'({key_ascii_i, key_scan_i})),
    .pop_i(keyb_pop), .dout_o(keyb_dout),
    .full_o(), .empty_o(), .almost_full_o(), .wr_err_o(), .rd_err_o(),
    .wr_count_o(), .rd_count_o()
  );

  sync_fifo #(.WIDTH(DATA_W), .DEPTH(FIFO_DEPTH)) tx_fifo (
    .msoc_clk(msoc_clk), .rstn(rstn), .clr_i(sd_fifo_clr),
    .push_i(tx_push), .din_i(hid_wrdata_i), .pop_i(sd_tx_rd_i), .dout_o(sd_tx_data_o),
    .full_o(tx_full), .empty_o(tx_empty), .almost_full_o(tx_almost_full),
    .wr_err_o(tx_wr_err), .rd_err_o(tx_rd_err),
    .wr_count_o(tx_wr_count), .rd_count_o(tx_rd_count)
  );

  sync_fifo #(.WIDTH(DATA_W), .DEPTH(FIFO_DEPTH)) rx_fifo (
    .msoc_clk(msoc_clk), .rstn(rstn), .clr_i(sd_fifo_clr),
    .push_i(sd_rx_we_i), .din_i(sd_rx_data_i), .pop_i(rx_pop), .dout_o(rx_dout),
    .full_o(rx_full), .empty_o(rx_empty), .almost_full_o(rx_almost_full),
    .wr_err_o(rx_wr_err), .rd_err_o(rx_rd_err),
    .wr_count_o(rx_wr_count), .rd_count_o(rx_rd_count)
  );

  sd_ctrl_regs u_sd_ctrl_regs (
    .msoc_clk(msoc_clk), .rstn(rstn), .wr_en_i(sd_reg_wr),
    .addr_i(sd_wr_addr_e'(hid_addr_i[3:0])), .wdata_i(hid_wrdata_i),
    .sd_align_o(sd_align_o), .sd_cmd_arg_o(sd_cmd_arg_o), .sd_cmd_idx_o(sd_cmd_idx_o),
    .sd_cmd_setting_o(sd_cmd_setting_o), .sd_data_start_o(sd_data_start_o),
    .sd_cmd_start_o(sd_cmd_start_o), .sd_blkcnt_o(sd_blkcnt_o),
    .sd_blksize_o(sd_blksize_o), .sd_timeout_o(sd_timeout_o),
    .sd_card_reset_o(sd_card_reset_o), .sd_clk_en_o(sd_clk_en_o),
    .sd_data_en_o(sd_data_en_o), .sd_cmd_en_o(sd_cmd_en_o), .to_led_o(to_led_o)
  );

  sd_status_mux u_sd_status_mux (
    .msoc_clk(msoc_clk), .rstn(rstn), .sel_i(sd_rd_sel_e'(hid_addr_i[4:0])),
    .sd_detect_i(sd_detect_i), .sd_status_i(sd_status_i),
    .sd_cmd_response_i(sd_cmd_response_i), .sd_cmd_wait_i(sd_cmd_wait_i),
    .sd_data_wait_i(sd_data_wait_i), .sd_cmd_packet_i(sd_cmd_packet_i),
    .sd_transf_cnt_i(sd_transf_cnt_i), .from_dip_i(from_dip_i),
    .tx_status_i(tx_status), .rx_status_i(rx_status),
    .tx_full_i(tx_full), .tx_empty_i(tx_empty), .rx_full_i(rx_full), .rx_empty_i(rx_empty),
    .sd_align_i(sd_align_o), .sd_cmd_arg_i(sd_cmd_arg_o), .sd_cmd_idx_i(sd_cmd_idx_o),
    .sd_cmd_setting_i(sd_cmd_setting_o), .sd_data_start_i(sd_data_start_o),
    .sd_cmd_start_i(sd_cmd_start_o), .sd_blkcnt_i(sd_blkcnt_o),
    .sd_blksize_i(sd_blksize_o), .sd_timeout_i(sd_timeout_o),
    .sd_card_reset_i(sd_card_reset_o), .sd_clk_en_i(sd_clk_en_o),
    .sd_data_en_i(sd_data_en_o), .sd_cmd_en_i(sd_cmd_en_o),
    .rdata_o(sd_rdata)
  );

endmodule

//--- design/sd_ctrl_regs.sv
// bus-written sd configuration, reset/enable and led registers
`timescale 1ns/1ns

module sd_ctrl_regs
  import periph_pkg::*;
(
  input  logic              msoc_clk,
  input  logic              rstn,
  input  logic              wr_en_i,   // qualified for register space
  input  sd_wr_addr_e       addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [1:0]        sd_align_o,
  output logic [31:0]       sd_cmd_arg_o,
  output logic [5:0]        sd_cmd_idx_o,
  output logic [2:0]        sd_cmd_setting_o,
  output logic [2:0]        sd_data_start_o,
  output logic              sd_cmd_start_o,
  output logic [15:0]       sd_blkcnt_o,
  output logic [11:0]       sd_blksize_o,
  output logic [31:0]       sd_timeout_o,
  output logic              sd_card_reset_o,
  output logic              sd_clk_en_o,
  output logic              sd_data_en_o,
  output logic              sd_cmd_en_o,
  output logic [7:0]        to_led_o
);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sd_align_o       <= '0;
      sd_cmd_arg_o     <= '0;
      sd_cmd_idx_o     <= '0;
      sd_cmd_setting_o <= '0;
      sd_data_start_o  <= '0;
      sd_cmd_start_o   <= 1'b0;
      sd_blkcnt_o      <= '0;
      sd_blksize_o     <= '0;
      sd_timeout_o     <= '0;
      sd_card_reset_o  <= 1'b0;
      sd_clk_en_o      <= 1'b0;
      sd_data_en_o     <= 1'b0;
      sd_cmd_en_o      <= 1'b0;
      to_led_o         <= '0;
    end
    else if (wr_en_i)
    begin
      case (addr_i)
        SD_ALIGN:
        begin
          sd_align_o <= wdata_i[1:0];
        end
        SD_CMD_ARG:
        begin
          sd_cmd_arg_o <= wdata_i[31:0];
        end
        SD_CMD_IDX:
        begin
          sd_cmd_idx_o <= wdata_i[5:0];
        end
        SD_SETTING:
        begin
          sd_data_start_o  <= wdata_i[5:3];
          sd_cmd_setting_o <= wdata_i[2:0];
        end
        SD_CMD_START:
        begin
          sd_cmd_start_o <= wdata_i[0];  // level, held until rewritten
        end
        SD_RESETS:
        begin
          sd_card_reset_o <= wdata_i[3];
          sd_clk_en_o     <= wdata_i[2];
          sd_data_en_o    <= wdata_i[1];  // low holds sd fifos cleared
          sd_cmd_en_o     <= wdata_i[0];
        end
        SD_BLKCNT:
        begin
          sd_blkcnt_o <= wdata_i[15:0];
        end
        SD_BLKSIZE:
        begin
          sd_blksize_o <= wdata_i[11:0];
        end
        SD_TIMEOUT:
        begin
          sd_timeout_o <= wdata_i[31:0];
        end
        SD_LED:
        begin
          to_led_o <= wdata_i[7:0];  // card activity and the like
        end
        default:
        begin
          // unlisted addresses ignored
        end
      endcase
    end
  end

endmodule

//--- design/sd_status_mux.sv
// registered readback word for the sd region: engine status, fifo status, config
`timescale 1ns/1ns

module sd_status_mux
  import periph_pkg::*;
(
  input  logic                msoc_clk,
  input  logic                rstn,
  input  sd_rd_sel_e          sel_i,
  input  logic                sd_detect_i,
  input  logic [27:0]         sd_status_i,
  input  logic [RESP_W-1:0]   sd_cmd_response_i,
  input  logic [DATA_W-1:0]   sd_cmd_wait_i,
  input  logic [DATA_W-1:0]   sd_data_wait_i,
  input  logic [PACKET_W-1:0] sd_cmd_packet_i,
  input  logic [15:0]         sd_transf_cnt_i,
  input  logic [15:0]         from_dip_i,
  input  logic [DATA_W-1:0]   tx_status_i,
  input  logic [DATA_W-1:0]   rx_status_i,
  input  logic                tx_full_i,
  input  logic                tx_empty_i,
  input  logic                rx_full_i,
  input  logic                rx_empty_i,
  input  logic [1:0]          sd_align_i,
  input  logic [31:0]         sd_cmd_arg_i,
  input  logic [5:0]          sd_cmd_idx_i,
  input  logic [2:0]          sd_cmd_setting_i,
  input  logic [2:0]          sd_data_start_i,
  input  logic                sd_cmd_start_i,
  input  logic [15:0]         sd_blkcnt_i,
  input  logic [11:0]         sd_blksize_i,
  input  logic [31:0]         sd_timeout_i,
  input  logic                sd_card_reset_i,
  input  logic                sd_clk_en_i,
  input  logic                sd_data_en_i,
  input  logic                sd_cmd_en_i,
  output logic [DATA_W-1:0]   rdata_o
);

  logic [DATA_W-1:0] sel_word;

  // engine inputs sampled with the select at the same edge
  always_comb
  begin
    case (sel_i)
      SEL_RESP0:      sel_word = sd_cmd_response_i[38:7];
      SEL_RESP1:      sel_word = sd_cmd_response_i[70:39];
      SEL_RESP2:      sel_word = sd_cmd_response_i[102:71];
      SEL_RESP3:      sel_word = DATA_W'(sd_cmd_response_i[RESP_W-1:103]);
      SEL_CMD_WAIT:   sel_word = sd_cmd_wait_i;
      SEL_STATUS:     sel_word = {sd_status_i, tx_full_i, tx_empty_i, rx_full_i, rx_empty_i};
      SEL_PACKET_LO:  sel_word = sd_cmd_packet_i[31:0];
      SEL_PACKET_HI:  sel_word = DATA_W'(sd_cmd_packet_i[PACKET_W-1:32]);
      SEL_DATA_WAIT:  sel_word = sd_data_wait_i;
      SEL_TRANSF_CNT: sel_word = DATA_W'(sd_transf_cnt_i);
      SEL_RX_STATUS:  sel_word = rx_status_i;
      SEL_TX_STATUS:  sel_word = tx_status_i;
      SEL_DETECT:     sel_word = DATA_W'(sd_detect_i);
      SEL_ALIGN:      sel_word = DATA_W'(sd_align_i);
      SEL_CMD_ARG:    sel_word = sd_cmd_arg_i;
      SEL_CMD_IDX:    sel_word = DATA_W'(sd_cmd_idx_i);
      SEL_SETTING:    sel_word = DATA_W'({sd_data_start_i, sd_cmd_setting_i});
      SEL_START:      sel_word = DATA_W'(sd_cmd_start_i);
      SEL_RESETS:
      begin
        sel_word = DATA_W'({sd_card_reset_i, sd_clk_en_i, sd_data_en_i, sd_cmd_en_i});
      end
      SEL_BLKCNT:     sel_word = DATA_W'(sd_blkcnt_i);
      SEL_BLKSIZE:    sel_word = DATA_W'(sd_blksize_i);
      SEL_TIMEOUT:    sel_word = sd_timeout_i;
      SEL_DIP:        sel_word = DATA_W'(from_dip_i);  // boot mode switches
      default:        sel_word = DEAD_WORD;            // unused select
    endcase
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
      rdata_o <= '0;
    else
      rdata_o <= sel_word;  // seen one cycle after the address
  end

endmodule

//--- design/sync_fifo.sv
// single-clock show-ahead fifo with counts, sticky error flags and level flags
`timescale 1ns/1ns

module sync_fifo
  import periph_pkg::*;
#(
  parameter int WIDTH = DATA_W,
  parameter int DEPTH = 16
)
(
  input  logic             msoc_clk,
  input  logic             rstn,
  input  logic             clr_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             full_o,
  output logic             empty_o,
  output logic             almost_full_o,
  output logic             wr_err_o,
  output logic             rd_err_o,
  output logic [CNT_W-1:0] wr_count_o,
  output logic [CNT_W-1:0] rd_count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occ;    // entries held
  logic             push_ok;
  logic             pop_ok;

  // pointer step, wraps for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign push_ok       = push_i && !full_o;  // push to full fifo dropped
  assign pop_ok        = pop_i && !empty_o;
  assign full_o        = (occ == OCC_W'(DEPTH));
  assign empty_o       = (occ == '0);
  assign almost_full_o = (occ >= OCC_W'(DEPTH - 1));
  assign dout_o        = mem[rd_ptr];        // head always visible

  always_ff @(posedge msoc_clk)
  begin
    if (push_ok)
      mem[wr_ptr] <= din_i;
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      wr_err_o   <= 1'b0;
      rd_err_o   <= 1'b0;
      wr_count_o <= '0;
      rd_count_o <= '0;
    end
    else if (clr_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      wr_err_o   <= 1'b0;
      rd_err_o   <= 1'b0;
      wr_count_o <= '0;
      rd_count_o <= '0;
    end
    else
    begin
      if (push_ok)
      begin
        wr_ptr     <= ptr_next(wr_ptr);
        wr_count_o <= wr_count_o + 1'b1;  // wraps at CNT_W
      end
      if (pop_ok)
      begin
        rd_ptr     <= ptr_next(rd_ptr);
        rd_count_o <= rd_count_o + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
      if (push_i && full_o)
        wr_err_o <= 1'b1;  // sticky until clear
      if (pop_i && empty_o)
        rd_err_o <= 1'b1;
    end
  end

endmodule

//--- periph_soc.f
design/periph_pkg.sv
design/sync_fifo.sv
design/sd_ctrl_regs.sv
design/sd_status_mux.sv
design/periph_soc.sv
verif/periph_soc_checker.sv
verif/periph_soc_tb.sv

//--- verif/periph_soc_checker.sv
// checker for periph_soc: read data, tx head and sd output comparison with error counts
`timescale 1ns/1ns

module periph_soc_checker
  import periph_pkg::*;
(
  input  logic              msoc_clk,
  input  logic              chk_rd_i,   // read word and sd outputs valid
  input  logic [DATA_W-1:0] act_rd_i,
  input  logic [DATA_W-1:0] exp_rd_i,
  input  logic [118:0]      act_sd_i,
  input  logic [118:0]      exp_sd_i,
  input  logic              chk_tx_i,   // tx head valid
  input  logic [DATA_W-1:0] act_tx_i,
  input  logic [DATA_W-1:0] exp_tx_i,
  output int                err_count_o,
  output int                check_count_o
);

  initial
  begin
    err_count_o   = 0;
    check_count_o = 0;
  end

  // sample mid-cycle, away from the driving edge
  always @(negedge msoc_clk)
  begin
    if (chk_rd_i)
    begin
      check_count_o = check_count_o + 2;
      if (act_rd_i !== exp_rd_i)
      begin
        err_count_o = err_count_o + 1;
        $display("FAILED at %0t: read data %h, expected %h", $time, act_rd_i, exp_rd_i);
      end
      if (act_sd_i !== exp_sd_i)
      begin
        err_count_o = err_count_o + 1;
        $display("FAILED at %0t: sd outputs %h, expected %h", $time, act_sd_i, exp_sd_i);
      end
    end
    if (chk_tx_i)
    begin
      check_count_o = check_count_o + 1;
      if (act_tx_i !== exp_tx_i)
      begin
        err_count_o = err_count_o + 1;
        $display("FAILED at %0t: tx head %h, expected %h", $time, act_tx_i, exp_tx_i);
      end
    end
  end

endmodule

//--- verif/periph_soc_tb.sv
// testbench top: clock, reset, bus and engine stimulus, fifo and register reference model
`timescale 1ns/1ns

module periph_soc_tb
  import periph_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int TOTAL_OPS  = 360;  // bus and engine ops in all test phases
  localparam int DEPTH      = 16;

  logic msoc_clk, rstn, hid_req, hid_we, key_valid, sd_detect, sd_tx_rd, sd_rx_we;
  logic [14:0] hid_addr;
  logic [31:0] hid_wrdata, hid_rddata, sd_cmd_wait, sd_data_wait, sd_rx_data, sd_tx_data;
  logic [6:0] key_ascii;
  logic [7:0] key_scan, to_led;
  logic [15:0] from_dip, sd_transf_cnt, sd_blkcnt;
  logic [27:0] sd_status;
  logic [RESP_W-1:0] sd_cmd_response;
  logic [PACKET_W-1:0] sd_cmd_packet;
  logic [1:0] sd_align;
  logic [31:0] sd_cmd_arg, sd_timeout;
  logic [5:0] sd_cmd_idx;
  logic [2:0] sd_cmd_setting, sd_data_start;
  logic [11:0] sd_blksize;
  logic sd_cmd_start, sd_card_reset, sd_clk_en, sd_data_en, sd_cmd_en;
  logic chk_rd, chk_tx;
  logic [31:0] exp_rd, exp_tx;
  logic [118:0] exp_sd;
  int err_count, check_count;
  integer seed = 32'h21d6_b821;

  logic [31:0] wr [16];                 // last word per register address
  logic [31:0] kb_q[$], tx_q[$], rx_q[$];
  logic [11:0] cnt_w [2], cnt_r [2];    // index 0 is tx and 1 is rx
  logic err_w [2], err_r [2];

  periph_soc #(.FIFO_DEPTH(DEPTH)) dut (
    .msoc_clk, .rstn, .hid_req_i(hid_req), .hid_we_i(hid_we), .hid_addr_i(hid_addr),
    .hid_wrdata_i(hid_wrdata), .hid_rddata_o(hid_rddata), .key_valid_i(key_valid),
    .key_ascii_i(key_ascii), .key_scan_i(key_scan), .from_dip_i(from_dip),
    .sd_detect_i(sd_detect), .sd_status_i(sd_status), .sd_cmd_response_i(sd_cmd_response),
    .sd_cmd_wait_i(sd_cmd_wait), .sd_data_wait_i(sd_data_wait),
    .sd_cmd_packet_i(sd_cmd_packet), .sd_transf_cnt_i(sd_transf_cnt),
    .sd_tx_rd_i(sd_tx_rd), .sd_rx_we_i(sd_rx_we), .sd_rx_data_i(sd_rx_data),
    .sd_tx_data_o(sd_tx_data), .to_led_o(to_led), .sd_align_o(sd_align),
    .sd_cmd_arg_o(sd_cmd_arg), .sd_cmd_idx_o(sd_cmd_idx), .sd_cmd_setting_o(sd_cmd_setting),
    .sd_data_start_o(sd_data_start), .sd_cmd_start_o(sd_cmd_start),
    .sd_blkcnt_o(sd_blkcnt), .sd_blksize_o(sd_blksize), .sd_timeout_o(sd_timeout),
    .sd_card_reset_o(sd_card_reset), .sd_clk_en_o(sd_clk_en), .sd_data_en_o(sd_data_en),
    .sd_cmd_en_o(sd_cmd_en)
  );

  periph_soc_checker u_checker (
    .msoc_clk, .chk_rd_i(chk_rd), .act_rd_i(hid_rddata), .exp_rd_i(exp_rd),
    .act_sd_i({to_led, sd_align, sd_cmd_arg, sd_cmd_idx, sd_cmd_setting, sd_data_start,
               sd_cmd_start, sd_blkcnt, sd_blksize, sd_timeout, sd_card_reset, sd_clk_en,
               sd_data_en, sd_cmd_en}),
    .exp_sd_i(exp_sd), .chk_tx_i(chk_tx), .act_tx_i(sd_tx_data), .exp_tx_i(exp_tx),
    .err_count_o(err_count), .check_count_o(check_count)
  );

  initial
  begin
    msoc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) msoc_clk = ~msoc_clk;
  end

  // expected sd outputs from the low bits of each written word
  function automatic logic [118:0] ref_sd();
    return {wr[15][7:0], wr[0][1:0], wr[2], wr[3][5:0], wr[4][2:0], wr[4][5:3], wr[5][0],
            wr[7][15:0], wr[8][11:0], wr[9], wr[6][3:0]};
  endfunction

  function automatic logic [31:0] fifo_status(int f);
    int n;
    n = (f == 0) ? tx_q.size() : rx_q.size();
    return {4'b0, n >= DEPTH - 1, n == DEPTH, err_r[f], err_w[f], cnt_r[f], cnt_w[f]};
  endfunction

  // expected read word for a word address
  function automatic logic [31:0] ref_read(logic [14:0] a);
    case (a[14:13])
      2'd0: return kb_q[0];
      2'd1: return 32'h0;
      2'd3: return rx_q[0];
      default:
      begin
        case (a[4:0])
          5'd0:  return sd_cmd_response[38:7];
          5'd1:  return sd_cmd_response[70:39];
          5'd2:  return sd_cmd_response[102:71];
          5'd3:  return 32'(sd_cmd_response[133:103]);
          5'd4:  return sd_cmd_wait;
          5'd5:
          begin
            return {sd_status, tx_q.size() == DEPTH, tx_q.size() == 0,
                    rx_q.size() == DEPTH, rx_q.size() == 0};
          end
          5'd6:  return sd_cmd_packet[31:0];
          5'd7:  return 32'(sd_cmd_packet[47:32]);
          5'd8:  return sd_data_wait;
          5'd9:  return 32'(sd_transf_cnt);
          5'd10: return fifo_status(1);
          5'd11: return fifo_status(0);
          5'd12: return 32'(sd_detect);
          5'd16: return 32'(wr[0][1:0]);
          5'd18: return wr[2];
          5'd19: return 32'(wr[3][5:0]);
          5'd20: return 32'(wr[4][5:0]);
          5'd21: return 32'(wr[5][0]);
          5'd22: return 32'(wr[6][3:0]);
          5'd23: return 32'(wr[7][15:0]);
          5'd24: return 32'(wr[8][11:0]);
          5'd25: return wr[9];
          5'd31: return 32'(from_dip);
          default: return DEAD_WORD;
        endcase
      end
    endcase
  endfunction

  // sd fifos follow the data enable bit
  task automatic apply_clear();
    if (!wr[6][1])
    begin
      tx_q.delete();
      rx_q.delete();
      cnt_w = '{default: '0};
      cnt_r = '{default: '0};
      err_w = '{default: 1'b0};
      err_r = '{default: 1'b0};
    end
  endtask

  task automatic start_op();
    @(posedge msoc_clk);
    hid_req   <= 1'b0;
    hid_we    <= 1'b0;
    key_valid <= 1'b0;
    sd_tx_rd  <= 1'b0;
    sd_rx_we  <= 1'b0;
    chk_rd    <= 1'b0;
    chk_tx    <= 1'b0;
  endtask

  task automatic fifo_push(int f, logic [31:0] d);
    if (!wr[6][1])
      return;
    if ((f == 0 ? tx_q.size() : rx_q.size()) == DEPTH)
      err_w[f] = 1'b1;  // dropped
    else
    begin
      if (f == 0)
        tx_q.push_back(d);
      else
        rx_q.push_back(d);
      cnt_w[f]++;
    end
  endtask

  task automatic fifo_pop(int f);
    if (!wr[6][1])
      return;
    if ((f == 0 ? tx_q.size() : rx_q.size()) == 0)
      err_r[f] = 1'b1;
    else
    begin
      if (f == 0)
        void'(tx_q.pop_front());
      else
        void'(rx_q.pop_front());
      cnt_r[f]++;
    end
  endtask

  task automatic bus_write(logic [14:0] a, logic [31:0] d);
    start_op();
    hid_req    <= 1'b1;
    hid_we     <= 1'b1;
    hid_addr   <= a;
    hid_wrdata <= d;
    case (a[14:13])
      2'd0:
      begin
        if (kb_q.size() > 0)
          void'(kb_q.pop_front());
      end
      2'd2:
      begin
        if (a[12])
          fifo_push(0, d);
        else
          wr[a[3:0]] = d;
      end
      2'd3: fifo_pop(1);
      default: ;
    endcase
    if (a[14:13] == 2'd2 && !a[12] && a[3:0] == 4'd6)
      start_op();  // let the fifo clear settle
    apply_clear();
  endtask

  task automatic check_read(logic [14:0] a);
    start_op();
    hid_req  <= 1'b1;
    hid_addr <= a;
    @(posedge msoc_clk);
    hid_req <= 1'b0;
    chk_rd  <= 1'b1;
    exp_rd  <= ref_read(a);
    exp_sd  <= ref_sd();
  endtask

  task automatic key_push();
    logic [6:0] ascii;
    logic [7:0] scan;
    ascii = 7'($random(seed));
    scan  = 8'($random(seed));
    start_op();
    key_valid <= 1'b1;
    key_ascii <= ascii;
    key_scan  <= scan;
    if (kb_q.size() < DEPTH)
      kb_q.push_back(32'({ascii, scan}));
  endtask

  task automatic tx_drain();
    start_op();
    sd_tx_rd <= 1'b1;
    if (tx_q.size() > 0)
    begin
      chk_tx <= 1'b1;
      exp_tx <= tx_q[0];
    end
    fifo_pop(0);
  endtask

  task automatic rx_fill(logic [31:0] d);
    start_op();
    sd_rx_we   <= 1'b1;
    sd_rx_data <= d;
    fifo_push(1, d);
  endtask

  task automatic engine_randomize();
    logic [159:0] rnd;
    rnd = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    start_op();
    sd_cmd_response <= rnd[RESP_W-1:0];
    sd_cmd_packet   <= {16'($random(seed)), 32'($random(seed))};
    sd_cmd_wait     <= $random(seed);
    sd_data_wait    <= $random(seed);
    sd_status       <= 28'($random(seed));
    sd_transf_cnt   <= 16'($random(seed));
    sd_detect       <= 1'($random(seed));
  endtask

  initial
  begin
    #((TOTAL_OPS * 2 + 50) * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    {hid_req, hid_we, key_valid, sd_tx_rd, sd_rx_we, chk_rd, chk_tx} = '0;
    {hid_addr, hid_wrdata, key_ascii, key_scan, sd_rx_data, exp_rd, exp_tx, exp_sd} = '0;
    {sd_detect, sd_status, sd_cmd_response, sd_cmd_wait, sd_data_wait} = '0;
    {sd_cmd_packet, sd_transf_cnt} = '0;
    from_dip = 16'($random(seed));
    wr = '{default: '0};
    rstn = 1'b0;
    apply_clear();
    repeat (3) @(posedge msoc_clk);
    rstn <= 1'b1;
    check_read(15'h4005);  // fifo flags after reset
    check_read(15'h401f);
    check_read(15'h2000);  // frame store region reads zero
    for (int r = 0; r < 3; r++)
    begin
      foreach (wr[i])
        if (i inside {0, 2, 3, 4, 5, 6, 7, 8, 9, 15})
          bus_write(15'h4000 | 15'(i), $random(seed));
      for (int s = 13; s < 26; s++)
        check_read(15'h4000 | 15'(s));
    end
    for (int k = 0; k < 12; k++)
      key_push();
    while (kb_q.size() > 0)
    begin
      check_read(15'h0000);
      bus_write(15'h0000, 32'h0);
    end
    bus_write(15'h4006, 32'h2);  // data enable on
    for (int k = 0; k < DEPTH + 2; k++)
      bus_write(15'h5000, $random(seed));
    check_read(15'h400b);
    for (int k = 0; k < DEPTH + 1; k++)
      tx_drain();
    check_read(15'h400b);
    check_read(15'h4005);
    for (int k = 0; k < 5; k++)
      bus_write(15'h5000, $random(seed));
    bus_write(15'h4006, 32'h0);  // disable clears both sd fifos
    check_read(15'h400b);
    bus_write(15'h4006, 32'h2);
    for (int k = 0; k < 8; k++)
      rx_fill($random(seed));
    check_read(15'h400a);
    while (rx_q.size() > 0)
    begin
      check_read(15'h6000);
      bus_write(15'h6000, 32'h0);
    end
    for (int r = 0; r < 10; r++)
    begin
      engine_randomize();
      for (int s = 0; s < 13; s++)
        check_read(15'h4000 | 15'(s));
    end
    start_op();
    @(posedge msoc_clk);
    @(negedge msoc_clk);
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
